// File: Bender.yml
package:
  name: mem_fabric

sources:
  - common/bus_pkg.sv
  - common/sdram_pkg.sv
  - rtl/beat_counter.sv
  - rtl/access_sequencer.sv
  - rtl/ram_bank.sv
  - sdram_bridge/sdram_lane_unit.sv
  - rtl/mem_fabric.sv
  - target: test
    files:
      - tests/sdram_model.sv
      - tests/tb_mem_fabric.sv

// File: common/bus_pkg.sv
package bus_pkg;

    // load/store type as the cpu encodes it
    // stores only use the four signed codes
    typedef enum logic [2:0] {
        ls_byte   = 3'b000,
        ls_half   = 3'b001,
        ls_word   = 3'b010,
        ls_double = 3'b011,
        ls_ubyte  = 3'b100,
        ls_uhalf  = 3'b101,
        ls_uword  = 3'b110
    } ls_type_e;

    // cpu request, held stable from strobe until done
    typedef struct packed {
        logic [63:0] addr;
        logic [63:0] wdata;
        ls_type_e    ls_type;
    } bus_req_t;

    // read word, filled per 32-bit word (ram) or per 16-bit half (sdram)
    typedef union packed {
        logic [1:0][31:0] words;
        logic [3:0][15:0] halves;
    } bus_data_u;

    typedef enum logic [1:0] {
        region_none,
        region_ram,
        region_sdram
    } region_e;

    // address map
    localparam logic [63:0] ram_base    = 64'h0000_0000_0000_1000;
    localparam logic [63:0] sdram_base  = 64'h0000_0000_0100_0000;
    localparam logic [63:0] sdram_limit = 64'h0000_0000_0180_0000;

    // sign or zero extension of a right-aligned load value
    function automatic logic [63:0] load_extend(logic [63:0] raw, ls_type_e t);
        case (t)
            ls_byte:  return {{56{raw[7]}}, raw[7:0]};
            ls_ubyte: return {56'b0, raw[7:0]};
            ls_half:  return {{48{raw[15]}}, raw[15:0]};
            ls_uhalf: return {48'b0, raw[15:0]};
            ls_word:  return {{32{raw[31]}}, raw[31:0]};
            ls_uword: return {32'b0, raw[31:0]};
            default:  return raw;
        endcase
    endfunction

endpackage

// File: common/sdram_pkg.sv
package sdram_pkg;

    // one beat towards the sdram controller
    // addr counts halfwords from the start of the sdram window
    typedef struct packed {
        logic [21:0] addr;
        logic [1:0]  byte_en;
        logic [15:0] wrdata;
        logic        rd;
        logic        wr;
    } sdram_req_t;

    // controller answer, req_wait low marks the completing cycle
    typedef struct packed {
        logic [15:0] rddata;
        logic        req_wait;
    } sdram_rsp_t;

    // doubleword = four halfword beats
    localparam int max_beats = 4;

    // byte enables, bit 0 is the low byte lane
    localparam logic [1:0] be_low  = 2'b01;
    localparam logic [1:0] be_high = 2'b10;
    localparam logic [1:0] be_both = 2'b11;

endpackage

// File: mem_fabric.f
common/bus_pkg.sv
common/sdram_pkg.sv
rtl/beat_counter.sv
rtl/access_sequencer.sv
rtl/ram_bank.sv
sdram_bridge/sdram_lane_unit.sv
rtl/mem_fabric.sv
tests/sdram_model.sv
tests/tb_mem_fabric.sv

// File: rtl/access_sequencer.sv
`timescale 1ns/1ps

module access_sequencer
    import bus_pkg::*;
#(
    parameter int ram_words = 1024
) (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  bus_req_t   bus_req,
    input  logic       read_en,
    input  logic       write_en,
    input  logic       last_beat,
    input  logic       beat_done,
    output region_e    region,
    output logic       beat_go,
    output logic       ram_rd,
    output logic       ram_wr,
    output logic [1:0] sdram_go,
    output logic       read_done,
    output logic       write_done
);

    typedef enum logic [1:0] {
        idle,
        ram_beat,
        sdram_beat,
        finish
    } state_e;

    localparam logic [63:0] ram_limit = ram_base + 64'(ram_words) * 64'd4;

    state_e  state;
    region_e decoded;
    logic    is_rd;
    logic    strobe;
    logic    done_now;

    assign strobe = read_en | write_en;

    // address decode, only sampled at the strobe
    always_comb begin
        if (bus_req.addr >= ram_base && bus_req.addr < ram_limit)
            decoded = region_ram;
        else if (bus_req.addr >= sdram_base && bus_req.addr < sdram_limit)
            decoded = region_sdram;
        else
            decoded = region_none;
    end

    // one memory steered per beat
    assign ram_rd      = (state == ram_beat) && is_rd;
    assign ram_wr      = (state == ram_beat) && !is_rd;
    assign sdram_go[0] = (state == sdram_beat) && is_rd;
    assign sdram_go[1] = (state == sdram_beat) && !is_rd;

    // ram beats take one cycle each, sdram beats wait for the controller
    assign beat_go = (state == ram_beat) || ((state == sdram_beat) && beat_done);

    assign done_now = (state == finish) || (beat_go && last_beat);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state      <= idle;
            region     <= region_none;
            is_rd      <= 1'b0;
            read_done  <= 1'b1;
            write_done <= 1'b1;
        end else begin
            if (state == idle) begin
                if (strobe) begin
                    region     <= decoded;
                    is_rd      <= read_en;
                    // only the strobed direction goes low
                    read_done  <= !read_en;
                    write_done <= !write_en;
                    case (decoded)
                        region_ram:   state <= ram_beat;
                        region_sdram: state <= sdram_beat;
                        default:      state <= finish;
                    endcase
                end
            end else if (done_now) begin
                state <= idle;
                if (is_rd)
                    read_done <= 1'b1;
                else
                    write_done <= 1'b1;
            end
        end
    end

    // cpu contract
    a_one_strobe: assert property (
        @(posedge CLOCK_50) disable iff (!KEY0) !(read_en && write_en));

    // single access in flight
    a_no_overlap: assert property (
        @(posedge CLOCK_50) disable iff (!KEY0) (state != idle) |-> !strobe);

endmodule

// File: rtl/beat_counter.sv
`timescale 1ns/1ps

module beat_counter
    import bus_pkg::*;
    import sdram_pkg::*;
(
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  ls_type_e   ls_type,
    input  region_e    region,
    input  logic       beat_go,
    input  logic       start,
    output logic [1:0] beat,
    output logic       last_beat
);

    logic [1:0] last_idx;

    // index of the final beat for this type and target
    always_comb begin
        last_idx = 2'd0;
        if (region == region_ram && ls_type == ls_double)
            last_idx = 2'd1;
        else if (region == region_sdram) begin
            case (ls_type)
                ls_word, ls_uword: last_idx = 2'd1;
                ls_double:         last_idx = 2'd3;
                default:           last_idx = 2'd0;
            endcase
        end
    end

    assign last_beat = (beat == last_idx);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0)
            beat <= 2'd0;
        else if (start)
            beat <= 2'd0;
        else if (beat_go && !last_beat)
            beat <= beat + 2'd1;
    end

    // counter must not wrap past the fourth beat
    a_no_wrap: assert property (
        @(posedge CLOCK_50) disable iff (!KEY0)
        (beat_go && beat == 2'(max_beats - 1)) |-> last_beat);

endmodule

// File: rtl/mem_fabric.sv
`timescale 1ns/1ps

module mem_fabric
    import bus_pkg::*;
    import sdram_pkg::*;
#(
    parameter int ram_words = 1024
) (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  bus_req_t   bus_req,
    input  logic       read_en,
    input  logic       write_en,
    input  sdram_rsp_t sdram_rsp,
    output bus_data_u  read_data,
    output logic       read_done,
    output logic       write_done,
    output sdram_req_t sdram_req
);

    region_e   region;
    logic      beat_go;
    logic      last_beat;
    logic [1:0] beat;
    logic      ram_rd;
    logic      ram_wr;
    // [0] read, [1] write
    logic [1:0] sdram_go;
    logic      beat_done;
    logic      strobe;
    bus_data_u ram_data;
    bus_data_u sdram_data;

    assign strobe = read_en | write_en;

    // unmapped reads give zero
    assign read_data = (region == region_ram)   ? ram_data   :
                       (region == region_sdram) ? sdram_data : '0;

    access_sequencer #(
        .ram_words (ram_words)
    ) u_seq (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .bus_req    (bus_req),
        .read_en    (read_en),
        .write_en   (write_en),
        .last_beat  (last_beat),
        .beat_done  (beat_done),
        .region     (region),
        .beat_go    (beat_go),
        .ram_rd     (ram_rd),
        .ram_wr     (ram_wr),
        .sdram_go   (sdram_go),
        .read_done  (read_done),
        .write_done (write_done)
    );

    beat_counter u_beats (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .ls_type   (bus_req.ls_type),
        .region    (region),
        .beat_go   (beat_go),
        .start     (strobe),
        .beat      (beat),
        .last_beat (last_beat)
    );

    ram_bank #(
        .ram_words (ram_words)
    ) u_ram (
        .CLOCK_50 (CLOCK_50),
        .bus_req  (bus_req),
        .beat     (beat),
        .ram_rd   (ram_rd),
        .ram_wr   (ram_wr),
        .ram_data (ram_data)
    );

    sdram_lane_unit u_lanes (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .bus_req    (bus_req),
        .beat       (beat),
        .sdram_go   (sdram_go),
        .sdram_rsp  (sdram_rsp),
        .sdram_req  (sdram_req),
        .beat_done  (beat_done),
        .sdram_data (sdram_data)
    );

endmodule

// File: rtl/ram_bank.sv
`timescale 1ns/1ps

module ram_bank
    import bus_pkg::*;
#(
    parameter int ram_words = 1024
) (
    input  logic       CLOCK_50,
    input  bus_req_t   bus_req,
    input  logic [1:0] beat,
    input  logic       ram_rd,
    input  logic       ram_wr,
    output bus_data_u  ram_data
);

    localparam int aw = $clog2(ram_words);

    logic [31:0]   mem [ram_words];
    logic [63:0]   idx_full;
    logic [aw-1:0] idx;
    logic [3:0]    wr_be;
    logic [31:0]   wr_word;
    logic [31:0]   rd_word;

    // word index from ram_base, doubleword high word sits one above
    assign idx_full = ((bus_req.addr - ram_base) >> 2) + 64'(beat);
    assign idx      = idx_full[aw-1:0];
    assign rd_word  = mem[idx];

    // byte lanes picked by the low address bits
    always_comb begin
        case (bus_req.ls_type)
            ls_byte: begin
                wr_be   = 4'b0001 << bus_req.addr[1:0];
                wr_word = {4{bus_req.wdata[7:0]}};
            end
            ls_half: begin
                wr_be   = bus_req.addr[1] ? 4'b1100 : 4'b0011;
                wr_word = {2{bus_req.wdata[15:0]}};
            end
            default: begin
                // word, or one half of a doubleword
                wr_be   = 4'b1111;
                wr_word = bus_req.wdata[{beat[0], 5'b0} +: 32];
            end
        endcase
    end

    always_ff @(posedge CLOCK_50) begin
        if (ram_wr) begin
            for (int i = 0; i < 4; i++) begin
                if (wr_be[i])
                    mem[idx][8*i +: 8] <= wr_word[8*i +: 8];
            end
        end
        if (ram_rd) begin
            if (bus_req.ls_type == ls_double)
                ram_data.words[beat[0]] <= rd_word;
            else
                // shift the addressed bytes down, then extend
                ram_data <= load_extend(64'(rd_word) >> {bus_req.addr[1:0], 3'b0},
                                        bus_req.ls_type);
        end
    end

    // decode upstream must keep every beat inside the array
    a_in_range: assert property (
        @(posedge CLOCK_50) (ram_rd || ram_wr) |-> (idx_full < 64'(ram_words)));

endmodule

// File: sdram_bridge/sdram_lane_unit.sv
`timescale 1ns/1ps

module sdram_lane_unit
    import bus_pkg::*;
    import sdram_pkg::*;
(
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  bus_req_t   bus_req,
    input  logic [1:0] beat,
    input  logic [1:0] sdram_go,
    input  sdram_rsp_t sdram_rsp,
    output sdram_req_t sdram_req,
    output logic       beat_done,
    output bus_data_u  sdram_data
);

    logic [63:0] offset;
    logic        rd_lvl;
    logic        wr_lvl;
    logic        byte_acc;
    ls_type_e    t;
    logic [15:0] rdh;

    assign t      = bus_req.ls_type;
    assign rdh    = sdram_rsp.rddata;
    assign offset = bus_req.addr - sdram_base;
    assign byte_acc = (t == ls_byte) || (t == ls_ubyte);

    // halfword address plus beat
    assign sdram_req.addr    = offset[22:1] + 22'(beat);
    assign sdram_req.byte_en = byte_acc ? (bus_req.addr[0] ? be_high : be_low) : be_both;
    // store byte goes on both lanes, byte_en picks one
    assign sdram_req.wrdata  = byte_acc ? {2{bus_req.wdata[7:0]}}
                                        : bus_req.wdata[{beat, 4'b0} +: 16];
    assign sdram_req.rd      = rd_lvl;
    assign sdram_req.wr      = wr_lvl;

    assign beat_done = (rd_lvl || wr_lvl) && !sdram_rsp.req_wait;

    // level held until req_wait drops, then one idle cycle between beats
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            rd_lvl <= 1'b0;
            wr_lvl <= 1'b0;
        end else if (beat_done) begin
            rd_lvl <= 1'b0;
            wr_lvl <= 1'b0;
        end else if (!rd_lvl && !wr_lvl) begin
            rd_lvl <= sdram_go[0];
            wr_lvl <= sdram_go[1];
        end
    end

    // read halves collected per beat
    always_ff @(posedge CLOCK_50) begin
        if (beat_done && rd_lvl) begin
            case (t)
                ls_byte, ls_ubyte:
                    sdram_data <= load_extend(64'(rdh) >> {bus_req.addr[0], 3'b0}, t);
                ls_half, ls_uhalf:
                    sdram_data <= load_extend(64'(rdh), t);
                ls_word, ls_uword: begin
                    if (beat == 2'd0)
                        sdram_data.halves[0] <= rdh;
                    else
                        // upper half of the word closes it, extend now
                        sdram_data <= load_extend({32'b0, rdh, sdram_data.halves[0]}, t);
                end
                default:
                    sdram_data.halves[beat] <= rdh;
            endcase
        end
    end

    // controller may stall a beat for any number of cycles
    a_req_stable: assert property (
        @(posedge CLOCK_50) disable iff (!KEY0)
        ((rd_lvl || wr_lvl) && sdram_rsp.req_wait) |=> $stable(sdram_req));

endmodule

// File: tests/sdram_model.sv
`timescale 1ns/1ps

module sdram_model
    import sdram_pkg::*;
(
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  sdram_req_t sdram_req,
    output sdram_rsp_t sdram_rsp,
    output int         beats,
    output logic [1:0] last_be
);

    // small halfword wide window of the sdram
    logic [15:0] mem [4096];
    logic [11:0] a;
    logic        busy;
    int          wait_left;

    initial begin
        // fill depends on every index bit
        for (int i = 0; i < 4096; i++)
            mem[i] = (16'(i) * 16'h9e37) ^ 16'h5a5a;
        sdram_rsp <= '{rddata: 16'h0, req_wait: 1'b1};
        beats     = 0;
        last_be   = 2'b00;
        busy      = 1'b0;
        wait_left = 0;
        void'($urandom(32'h79b8_63ae));
        forever begin
            @(posedge CLOCK_50);
            a = sdram_req.addr[11:0];
            if (!KEY0) begin
                sdram_rsp.req_wait <= 1'b1;
                busy = 1'b0;
            end else if (sdram_req.rd || sdram_req.wr) begin
                if (!sdram_rsp.req_wait) begin
                    // beat completes on this edge
                    if (sdram_req.wr && sdram_req.byte_en[0])
                        mem[a][7:0] = sdram_req.wrdata[7:0];
                    if (sdram_req.wr && sdram_req.byte_en[1])
                        mem[a][15:8] = sdram_req.wrdata[15:8];
                    beats   = beats + 1;
                    last_be = sdram_req.byte_en;
                    sdram_rsp.req_wait <= 1'b1;
                    busy = 1'b0;
                end else if (!busy) begin
                    // new request, pick its stall length
                    busy      = 1'b1;
                    wait_left = $urandom % 4;
                end else if (wait_left == 0) begin
                    sdram_rsp.rddata   <= mem[a];
                    sdram_rsp.req_wait <= 1'b0;
                end else begin
                    wait_left = wait_left - 1;
                end
            end
        end
    end

endmodule

// File: tests/tb_mem_fabric.sv
`timescale 1ns/1ps

module tb_mem_fabric
    import bus_pkg::*;
    import sdram_pkg::*;
;

    // worst case sum of all tests is near 900 cycles
    localparam int timeout_cycles = 4000;

    logic       CLOCK_50;
    logic       KEY0;
    bus_req_t   bus_req;
    logic       read_en;
    logic       write_en;
    sdram_rsp_t sdram_rsp;
    bus_data_u  read_data;
    logic       read_done;
    logic       write_done;
    sdram_req_t sdram_req;
    int         sdram_beats;
    logic [1:0] sdram_last_be;
    int         cycle_count = 0;

    // expected memory contents by byte address
    logic [7:0] ref_bytes [logic [63:0]];

    mem_fabric #(
        .ram_words (1024)
    ) uut (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .bus_req    (bus_req),
        .read_en    (read_en),
        .write_en   (write_en),
        .sdram_rsp  (sdram_rsp),
        .read_data  (read_data),
        .read_done  (read_done),
        .write_done (write_done),
        .sdram_req  (sdram_req)
    );

    sdram_model sdram_ctrl (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .sdram_req (sdram_req),
        .sdram_rsp (sdram_rsp),
        .beats     (sdram_beats),
        .last_be   (sdram_last_be)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #2 CLOCK_50 = ~CLOCK_50;
    end

    always @(posedge CLOCK_50) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == timeout_cycles) begin
            $display("run timed out after %0d cycles", cycle_count);
            $display("sim failed");
            $fatal(1, "no completion before the cycle limit");
        end
    end

    task automatic check_data(input string name, input bus_data_u exp, input bus_data_u act);
        if (act !== exp) begin
            $display("error %s expected %h actual %h", name, exp, act);
            $display("sim failed");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_done(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error %s expected %b actual %b", name, exp, act);
            $display("sim failed");
            $fatal(1, "level mismatch");
        end
    endtask

    task automatic check_beats(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("error %s beats expected %0d actual %0d", name, exp, act);
            $display("sim failed");
            $fatal(1, "beat count mismatch");
        end
    endtask

    task automatic check_byte_en(input string name, input logic [1:0] exp,
                                 input logic [1:0] act);
        if (act !== exp) begin
            $display("error %s byte_en expected %b actual %b", name, exp, act);
            $display("sim failed");
            $fatal(1, "byte enable mismatch");
        end
    endtask

    function automatic int access_bytes(input ls_type_e t);
        case (t)
            ls_byte, ls_ubyte: return 1;
            ls_half, ls_uhalf: return 2;
            ls_word, ls_uword: return 4;
            default:           return 8;
        endcase
    endfunction

    // one halfword beat per two bytes and a whole beat for a single byte
    function automatic int beats_for(input ls_type_e t);
        return (access_bytes(t) + 1) / 2;
    endfunction

    task automatic ref_store(input logic [63:0] addr, input logic [63:0] data,
                             input ls_type_e t);
        int i;
        for (i = 0; i < access_bytes(t); i++)
            ref_bytes[addr + 64'(i)] = data[8*i +: 8];
    endtask

    // little endian gather followed by sign or zero fill above the value
    function automatic logic [63:0] ref_load(input logic [63:0] addr, input ls_type_e t);
        int          i;
        int          n;
        logic [63:0] v;
        n = access_bytes(t);
        v = '0;
        for (i = 0; i < n; i++)
            v[8*i +: 8] = ref_bytes[addr + 64'(i)];
        if ((t == ls_byte || t == ls_half || t == ls_word) && v[8*n-1])
            v = v | ~((64'd1 << (8*n)) - 64'd1);
        return v;
    endfunction

    // strobe one access and wait for done
    // lat 0 waits on the done level
    // a nonzero lat wants done exactly lat edges after the strobe
    task automatic run_access(input string name, input logic [63:0] addr,
                              input logic [63:0] wdata, input ls_type_e t,
                              input logic wr, input int lat);
        int   cycles;
        int   beats_before;
        logic in_sdram;
        in_sdram     = (addr >= sdram_base) && (addr < sdram_limit);
        beats_before = sdram_beats;
        bus_req  = '{addr: addr, wdata: wdata, ls_type: t};
        read_en  = !wr;
        write_en = wr;
        @(posedge CLOCK_50);
        #1;
        read_en  = 1'b0;
        write_en = 1'b0;
        check_done(name, 1'b0, wr ? write_done : read_done);
        if (lat > 0) begin
            for (cycles = 2; cycles <= lat; cycles++) begin
                @(posedge CLOCK_50);
                #1;
                check_done(name, cycles == lat, wr ? write_done : read_done);
            end
        end else begin
            while ((wr ? write_done : read_done) !== 1'b1) begin
                @(posedge CLOCK_50);
                #1;
            end
        end
        if (in_sdram) begin
            check_beats(name, beats_for(t), sdram_beats - beats_before);
            if (wr && t == ls_byte)
                check_byte_en(name, addr[0] ? 2'b10 : 2'b01, sdram_last_be);
        end
    endtask

    task automatic store(input string name, input logic [63:0] addr,
                         input logic [63:0] data, input ls_type_e t, input int lat);
        run_access(name, addr, data, t, 1'b1, lat);
        ref_store(addr, data, t);
    endtask

    task automatic load(input string name, input logic [63:0] addr,
                        input ls_type_e t, input int lat);
        run_access(name, addr, 64'h0, t, 1'b0, lat);
        check_data(name, bus_data_u'(ref_load(addr, t)), read_data);
    endtask

    // six narrow load types at every aligned offset of one word
    task automatic load_all_types(input string name, input logic [63:0] base, input int lat);
        int off;
        for (off = 0; off < 4; off++) begin
            load($sformatf("%s lb %0d", name, off), base + 64'(off), ls_byte, lat);
            load($sformatf("%s lbu %0d", name, off), base + 64'(off), ls_ubyte, lat);
        end
        for (off = 0; off < 4; off += 2) begin
            load($sformatf("%s lh %0d", name, off), base + 64'(off), ls_half, lat);
            load($sformatf("%s lhu %0d", name, off), base + 64'(off), ls_uhalf, lat);
        end
        load({name, " lw"}, base, ls_word, lat);
        load({name, " lwu"}, base, ls_uword, lat);
    endtask

    task automatic reset_levels();
        check_done("reset read_done", 1'b1, read_done);
        check_done("reset write_done", 1'b1, write_done);
        check_done("reset sdram rd", 1'b0, sdram_req.rd);
        check_done("reset sdram wr", 1'b0, sdram_req.wr);
        check_data("reset read_data", '0, read_data);
    endtask

    // word, byte and half stores into one word with a full load sweep after each
    task automatic small_access_sweep(input string name, input logic [63:0] base,
                                      input int lat);
        int         off;
        logic [7:0] bv;
        store({name, " sw"}, base, 64'h0000_0000_8765_43a9, ls_word, lat);
        load_all_types({name, " after sw"}, base, lat);
        for (off = 0; off < 4; off++) begin
            // mixed sign bits across lanes
            bv = 8'h71 + 8'(off) * 8'h38;
            store($sformatf("%s sb %0d", name, off), base + 64'(off), 64'(bv), ls_byte, lat);
        end
        load_all_types({name, " after sb"}, base, lat);
        store({name, " sh 0"}, base, 64'h0000_0000_0000_f0e1, ls_half, lat);
        store({name, " sh 2"}, base + 64'd2, 64'h0000_0000_0000_7fc2, ls_half, lat);
        load_all_types({name, " after sh"}, base, lat);
    endtask

    task automatic double_round_trip(input string name, input logic [63:0] addr,
                                     input int lat_double, input int lat_word);
        store({name, " sd"}, addr, 64'hf00d_cafe_8001_7ffe, ls_double, lat_double);
        load({name, " ld"}, addr, ls_double, lat_double);
        // high word alone with sign and zero extension
        load({name, " lw hi"}, addr + 64'd4, ls_word, lat_word);
        load({name, " lwu hi"}, addr + 64'd4, ls_uword, lat_word);
    endtask

    task automatic unmapped_access();
        run_access("unmapped low rd", 64'h0000_0000_0000_0800, 64'h0, ls_word, 1'b0, 2);
        check_data("unmapped low rd", '0, read_data);
        run_access("unmapped wr", 64'h0000_0000_0000_0800, 64'h1234, ls_word, 1'b1, 2);
        // first word past the ram array
        run_access("past ram rd", ram_base + 64'd4096, 64'h0, ls_double, 1'b0, 2);
        check_data("past ram rd", '0, read_data);
        run_access("past sdram rd", sdram_limit, 64'h0, ls_half, 1'b0, 2);
        check_data("past sdram rd", '0, read_data);
    endtask

    initial begin
        KEY0     = 1'b0;
        read_en  = 1'b0;
        write_en = 1'b0;
        bus_req  = '0;
        repeat (3) @(posedge CLOCK_50);
        #1;
        KEY0 = 1'b1;
        reset_levels();
        small_access_sweep("ram", ram_base + 64'h40, 2);
        double_round_trip("ram", ram_base + 64'h80, 3, 2);
        small_access_sweep("sdram", sdram_base + 64'h200, 0);
        double_round_trip("sdram", sdram_base + 64'h208, 0, 0);
        double_round_trip("sdram top", sdram_limit - 64'h8, 0, 0);
        unmapped_access();
        $display("sim passed");
        $finish;
    end

endmodule
